// File: verilog.f
verilog/mipsPkg.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/dataMemory.sv
verilog/mipsCore.sv
bench/mipsCore_checker.sv
bench/mipsCoreTb.sv

// File: bench/mipsCoreTb.sv
// Preloads the data memory through the hierarchy and drives one table row per clock cycle.
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*; ();

  localparam int    ClkPeriod   = 20;
  localparam int    ResetCycles = 5;
  localparam word_t NoOp        = 32'hFC00_0000;  // Opcode 63, all fields zero.

  typedef struct packed {
    word_t instr;
    word_t pc;
    logic  memWrite;
    word_t aluResult;
    word_t writeData;
  } row_t;

  logic  clk;
  logic  rstN;
  word_t instr;
  word_t pc;
  word_t aluResult;
  word_t writeData;
  logic  memWrite;

  row_t rows [$];
  int   errorCount;
  int   currentRow;
  bit   tableReady;

  mipsCore i_dut (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (instr),
    .pc        (pc),
    .aluResult (aluResult),
    .writeData (writeData),
    .memWrite  (memWrite)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // -------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------
  // Odd words are negative, even words positive.
  function automatic word_t fillWord(int idx);
    word_t w;
    w = idx * 32'h0001_0203 + 32'h11;
    if (idx % 2 == 1) begin
      w = w | 32'hF000_0000;
    end
    return w;
  endfunction

  function automatic word_t encodeRType(regAddr_t rs, regAddr_t rt, regAddr_t rd, funct_t fn);
    return {OpRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t encodeIType(opcode_t op, regAddr_t rs, regAddr_t rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic addRow(word_t ins, word_t expPc, logic expMw, word_t expAlu, word_t expWd);
    row_t r;
    r.instr     = ins;
    r.pc        = expPc;
    r.memWrite  = expMw;
    r.aluResult = expAlu;
    r.writeData = expWd;
    rows.push_back(r);
  endtask

  task automatic checkWord(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns, row %0d: %s expected %h, got %h",
               $time, currentRow, name, expected, actual);
    end
  endtask

  task automatic checkBit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t ns, row %0d: %s expected %b, got %b",
               $time, currentRow, name, expected, actual);
    end
  endtask

  // -------------------------------------------------------------------
  // Program and expected results
  // -------------------------------------------------------------------
  task automatic buildTable();
    word_t valA;
    word_t valB;
    word_t valC;
    word_t valD;
    valA = fillWord(2);
    valB = fillWord(3);  // Negative.
    valC = fillWord(4);
    valD = fillWord(1);  // Negative, below valB.
    addRow(NoOp, 32'd0, 1'b0, 32'd0, 32'd0);
    addRow(NoOp, 32'd4, 1'b0, 32'd0, 32'd0);
    addRow(encodeIType(OpLw, 5'd0, 5'd1, 16'd8),  32'd8,  1'b0, 32'd8,  32'd0);
    addRow(encodeIType(OpLw, 5'd0, 5'd2, 16'd12), 32'd12, 1'b0, 32'd12, 32'd0);
    addRow(encodeIType(OpLw, 5'd0, 5'd3, 16'd16), 32'd16, 1'b0, 32'd16, 32'd0);
    addRow(encodeIType(OpLw, 5'd0, 5'd4, 16'd4),  32'd20, 1'b0, 32'd4,  32'd0);
    // Round trip through word 40.
    addRow(encodeIType(OpSw, 5'd0, 5'd1, 16'd160), 32'd24, 1'b1, 32'd160, valA);
    addRow(encodeIType(OpLw, 5'd0, 5'd5, 16'd160), 32'd28, 1'b0, 32'd160, 32'd0);
    addRow(encodeIType(OpSw, 5'd0, 5'd5, 16'd164), 32'd32, 1'b1, 32'd164, valA);
    addRow(encodeRType(5'd1, 5'd3, 5'd6,  FunctAdd), 32'd36, 1'b0, valA + valC, valC);
    addRow(encodeRType(5'd1, 5'd3, 5'd7,  FunctSub), 32'd40, 1'b0, valA - valC, valC);
    addRow(encodeRType(5'd1, 5'd2, 5'd8,  FunctAnd), 32'd44, 1'b0, valA & valB, valB);
    addRow(encodeRType(5'd1, 5'd2, 5'd9,  FunctOr),  32'd48, 1'b0, valA | valB, valB);
    addRow(encodeRType(5'd2, 5'd1, 5'd10, FunctSlt), 32'd52, 1'b0, 32'd1, valA);
    addRow(encodeRType(5'd1, 5'd2, 5'd11, FunctSlt), 32'd56, 1'b0, 32'd0, valB);
    addRow(encodeRType(5'd4, 5'd2, 5'd12, FunctSlt), 32'd60, 1'b0, 32'd1, valB);
    addRow(encodeIType(OpSw, 5'd0, 5'd6,  16'd168), 32'd64, 1'b1, 32'd168, valA + valC);
    addRow(encodeIType(OpSw, 5'd0, 5'd10, 16'd172), 32'd68, 1'b1, 32'd172, 32'd1);
    // Taken beq skips two words, then one not taken.
    addRow(encodeIType(OpBeq, 5'd1, 5'd5, 16'd2), 32'd72, 1'b0, 32'd0, valA);
    addRow(encodeIType(OpBeq, 5'd1, 5'd2, 16'd3), 32'd84, 1'b0, valA - valB, valB);
    // Register zero ignores the write.
    addRow(encodeRType(5'd1, 5'd3, 5'd0, FunctAdd), 32'd88, 1'b0, valA + valC, valC);
    addRow(encodeIType(OpSw, 5'd0, 5'd0, 16'd176), 32'd92, 1'b1, 32'd176, 32'd0);
    addRow(encodeRType(5'd1, 5'd3, 5'd13, 6'd39), 32'd96, 1'b0, valA + valC, valC);
    addRow(encodeIType(OpSw, 5'd0, 5'd13, 16'd180), 32'd100, 1'b1, 32'd180, valA + valC);
    addRow(encodeIType(OpLw, 5'd0, 5'd14, 16'd164), 32'd104, 1'b0, 32'd164, 32'd0);
    addRow(encodeIType(OpSw, 5'd0, 5'd14, 16'd184), 32'd108, 1'b1, 32'd184, valA);
    addRow(encodeIType(OpBeq, 5'd0, 5'd0, 16'd1), 32'd112, 1'b0, 32'd0, 32'd0);
    addRow(encodeIType(OpBeq, 5'd4, 5'd4, 16'hFFFD), 32'd120, 1'b0, 32'd0, valD);  // Back 3.
    addRow(NoOp, 32'd112, 1'b0, 32'd0, 32'd0);
    addRow(NoOp, 32'd116, 1'b0, 32'd0, 32'd0);
  endtask

  // -------------------------------------------------------------------
  // Stimulus and checks
  // -------------------------------------------------------------------
  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    instr      = NoOp;
    errorCount = 0;
    currentRow = 0;
    for (int i = 0; i < DataWords; i++) begin
      i_dut.i_dataMemory.mem[i] = fillWord(i);
    end
    buildTable();
    tableReady = 1'b1;

    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    foreach (rows[r]) begin
      if (r > 0) begin
        @(posedge clk);
      end
      instr <= rows[r].instr;
      currentRow = r;
      #(ClkPeriod - 2);                                  // Just before the next edge.
      checkWord("pc", rows[r].pc, pc);
      checkBit("memWrite", rows[r].memWrite, memWrite);
      checkWord("aluResult", rows[r].aluResult, aluResult);
      checkWord("writeData", rows[r].writeData, writeData);
    end
    @(posedge clk);
    instr <= NoOp;
    @(posedge clk);
    #(ClkPeriod / 2);                                  // Past the last assertion sample.

    $display("Checks done over %0d rows with %0d errors and %0d assertion failures",
             rows.size(), errorCount, i_dut.i_checker.failCount);
    if (errorCount == 0 && i_dut.i_checker.failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (tableReady);
    #((ResetCycles + rows.size() + 10) * ClkPeriod);
    $display("Timeout: the test did not finish in time, %0d errors and %0d assertion failures",
             errorCount, i_dut.i_checker.failCount);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: bench/mipsCore_checker.sv
// Checks pc alignment, the pc step of 4 after every non-beq instruction, and memWrite low in reset.
`timescale 1ns/10ps

module mipsCore_checker import mipsPkg::*; (
  input logic  clk,
  input logic  rstN,
  input word_t pc,
  input word_t instr,
  input logic  memWrite
);

  int failCount = 0;  // Read by the testbench.

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else begin
      failCount++;
      $error("pc is not word aligned, pc = %h", pc);
    end

  // Only beq may leave the sequential path.
  pcStep: assert property (@(posedge clk) disable iff (!rstN)
    (instr[31:26] != OpBeq) |=> (pc == $past(pc) + 32'd4))
    else begin
      failCount++;
      $error("pc did not advance by 4, pc = %h", pc);
    end

  noStoreInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
    else begin
      failCount++;
      $error("memWrite is high during reset");
    end

endmodule

bind mipsCore mipsCore_checker i_checker (
  .clk      (clk),
  .rstN     (rstN),
  .pc       (pc),
  .instr    (instr),
  .memWrite (memWrite)
);

// File: verilog/mipsCore.sv
// Single-cycle core where instr must be valid every cycle and a no-op must be driven during reset.
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  word_t instr,
  output word_t pc,
  output word_t aluResult,
  output word_t writeData,
  output logic  memWrite
);

  // Instruction fields.
  opcode_t  opcode;
  funct_t   funct;
  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;

  // Control levels.
  logic        regWrite;
  logic        regDst;
  logic        aluSrc;
  logic        branch;
  logic        memToReg;
  aluControl_t aluControl;

  // Datapath.
  word_t    signImm;
  word_t    readData1;
  word_t    readData2;
  word_t    srcB;
  word_t    memReadData;
  word_t    result;
  regAddr_t writeReg;
  logic     zero;
  logic     pcSrc;
  word_t    pcPlus4;
  word_t    pcBranch;
  word_t    pcNext;

  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign funct  = instr[5:0];

  assign signImm = {{16{instr[15]}}, instr[15:0]};

  // -------------------------------------------------------------------
  // Program counter
  // -------------------------------------------------------------------
  assign pcPlus4  = pc + 32'd4;
  assign pcBranch = pcPlus4 + {signImm[29:0], 2'b00};  // Offset in words.
  assign pcSrc    = branch & zero;
  assign pcNext   = pcSrc ? pcBranch : pcPlus4;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // -------------------------------------------------------------------
  // Decode
  // -------------------------------------------------------------------
  controlUnit i_controlUnit (
    .opcode     (opcode),
    .funct      (funct),
    .regWrite   (regWrite),
    .regDst     (regDst),
    .aluSrc     (aluSrc),
    .branch     (branch),
    .memWrite   (memWrite),
    .memToReg   (memToReg),
    .aluControl (aluControl)
  );

  // -------------------------------------------------------------------
  // Register file and ALU
  // -------------------------------------------------------------------
  assign writeReg = regDst ? rd : rt;

  registerFile i_registerFile (
    .clk       (clk),
    .rstN      (rstN),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeReg),
    .writeEn   (regWrite),
    .writeData (result),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  assign srcB = aluSrc ? signImm : readData2;

  alu i_alu (
    .a          (readData1),
    .b          (srcB),
    .aluControl (aluControl),
    .result     (aluResult),
    .zero       (zero)
  );

  // -------------------------------------------------------------------
  // Memory and write-back
  // -------------------------------------------------------------------
  assign writeData = readData2;  // Store data from rt.

  dataMemory i_dataMemory (
    .clk       (clk),
    .writeEn   (memWrite),
    .wordAddr  (aluResult[DataAddrBits+1:2]),
    .writeData (writeData),
    .readData  (memReadData)
  );

  assign result = memToReg ? memReadData : aluResult;

endmodule

// File: verilog/dataMemory.sv
// Word-addressed only with no byte enables, and the contents are undefined until written.
`timescale 1ns/10ps

module dataMemory import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    writeEn,
  input  logic [DataAddrBits-1:0] wordAddr,
  input  word_t                   writeData,
  output word_t                   readData
);

  word_t mem [DataWords];

  // Store on the rising edge.
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[wordAddr] <= writeData;
    end
  end

  // Load path, same-cycle write not visible.
  assign readData = mem[wordAddr];

endmodule

// File: verilog/registerFile.sv
// Reads are combinational and return the old value during a write, and register zero always reads 0.
`timescale 1ns/10ps

module registerFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  regAddr_t readAddr1,
  input  regAddr_t readAddr2,
  input  regAddr_t writeAddr,
  input  logic     writeEn,
  input  word_t    writeData,
  output word_t    readData1,
  output word_t    readData2
);

  word_t regs [32];

  // -------------------------------------------------------------------
  // Write port
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // -------------------------------------------------------------------
  // Read ports
  // -------------------------------------------------------------------
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];  // $zero.
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: verilog/alu.sv
// Set-less-than compares the operands as signed values and unused control codes give a zero result.
`timescale 1ns/10ps

module alu import mipsPkg::*; (
  input  word_t       a,
  input  word_t       b,
  input  aluControl_t aluControl,
  output word_t       result,
  output logic        zero
);

  logic lessThan;

  assign lessThan = ($signed(a) < $signed(b));

  always_comb begin
    case (aluControl)
      AluAnd: begin
        result = a & b;
      end
      AluOr: begin
        result = a | b;
      end
      AluAdd: begin
        result = a + b;
      end
      AluSub: begin
        result = a - b;
      end
      AluSlt: begin
        result = {31'd0, lessThan};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Used by beq after subtract.
  assign zero = (result == '0);

endmodule

// File: verilog/controlUnit.sv
// Opcodes outside R-type, lw, sw and beq decode as a no-op and an unknown funct selects add.
`timescale 1ns/10ps

module controlUnit import mipsPkg::*; (
  input  opcode_t     opcode,
  input  funct_t      funct,
  output logic        regWrite,
  output logic        regDst,
  output logic        aluSrc,
  output logic        branch,
  output logic        memWrite,
  output logic        memToReg,
  output aluControl_t aluControl
);

  aluOp_t aluOp;

  // -------------------------------------------------------------------
  // Main decoder
  // -------------------------------------------------------------------
  always_comb begin
    regWrite = 1'b0;        // No-op unless matched below.
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    branch   = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    aluOp    = AluOpMem;
    case (opcode)
      OpRType: begin
        regWrite = 1'b1;
        regDst   = 1'b1;    // Write to rd.
        aluOp    = AluOpRType;
      end
      OpLw: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        aluOp    = AluOpMem;
      end
      OpSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = AluOpMem;
      end
      OpBeq: begin
        branch   = 1'b1;
        aluOp    = AluOpBranch;
      end
      default: ;            // Other opcodes keep the no-op levels.
    endcase
  end

  // -------------------------------------------------------------------
  // ALU decoder
  // -------------------------------------------------------------------
  always_comb begin
    case (aluOp)
      AluOpMem:    aluControl = AluAdd;
      AluOpBranch: aluControl = AluSub;
      AluOpRType: begin
        case (funct)
          FunctAdd: aluControl = AluAdd;
          FunctSub: aluControl = AluSub;
          FunctAnd: aluControl = AluAnd;
          FunctOr:  aluControl = AluOr;
          FunctSlt: aluControl = AluSlt;
          default:  aluControl = AluAdd;  // Unknown funct.
        endcase
      end
      default:     aluControl = AluAdd;
    endcase
  end

endmodule

// File: verilog/mipsPkg.sv
// Encodings cover only add, sub, and, or, slt, lw, sw and beq, and the data memory holds 64 words.
package mipsPkg;

  // -------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------
  typedef logic [31:0] word_t;        // Data word, instruction or address.
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [1:0]  aluOp_t;       // Class from main decoder to ALU decoder.
  typedef logic [2:0]  aluControl_t;

  // -------------------------------------------------------------------
  // Instruction encodings
  // -------------------------------------------------------------------
  localparam opcode_t OpRType = 6'd0;
  localparam opcode_t OpLw    = 6'd35;
  localparam opcode_t OpSw    = 6'd43;
  localparam opcode_t OpBeq   = 6'd4;

  localparam funct_t FunctAdd = 6'd32;
  localparam funct_t FunctSub = 6'd34;
  localparam funct_t FunctAnd = 6'd36;
  localparam funct_t FunctOr  = 6'd37;
  localparam funct_t FunctSlt = 6'd42;

  // ALU operation classes and codes.
  localparam aluOp_t AluOpMem    = 2'b00;  // Address add.
  localparam aluOp_t AluOpBranch = 2'b01;  // Compare by subtract.
  localparam aluOp_t AluOpRType  = 2'b10;  // Decided by funct.

  localparam aluControl_t AluAnd = 3'd0;
  localparam aluControl_t AluOr  = 3'd1;
  localparam aluControl_t AluAdd = 3'd2;
  localparam aluControl_t AluSub = 3'd6;
  localparam aluControl_t AluSlt = 3'd7;

  // Data memory geometry.
  localparam int DataWords    = 64;
  localparam int DataAddrBits = 6;

endpackage
